//--- build.f
hw/noc_config_pkg.sv
hw/noc_flit_pkg.sv
hw/noc_flit_if.sv
hw/noc_vc_steer.sv
hw/noc_vc_buffer.sv
hw/noc_vc_arbiter_mux.sv
hw/noc_output_port.sv
tb/tb_clock_gen.sv
tb/noc_output_port_tb.sv

//--- hw/noc_config_pkg.sv
package noc_config_pkg;

  // default sizes of one router output port.
  localparam int NOC_CHANNELS   = 4;   // virtual channels.
  localparam int NOC_DEPTH      = 4;   // flit entries per vc buffer.
  localparam int NOC_DATA_WIDTH = 16;  // payload bits per flit.

  // width of a vc index.
  // a single channel still gets one bit so that no vector is zero wide.
  function automatic int noc_vc_width(int channels);
    return (channels > 1) ? $clog2(channels) : 1;
  endfunction

endpackage

//--- hw/noc_flit_if.sv
`timescale 1ns/1ps

interface noc_flit_if
  import noc_config_pkg::*, noc_flit_pkg::*;
#(
  parameter int CHANNELS   = NOC_CHANNELS,
  parameter int DATA_WIDTH = NOC_DATA_WIDTH
);
  localparam int VC_WIDTH = noc_vc_width(CHANNELS);

  logic                  valid;
  logic                  ready;
  logic [VC_WIDTH-1:0]   vc;    // virtual channel of the flit.
  noc_flit_kind_e        kind;
  logic [DATA_WIDTH-1:0] data;

  // sender side of the link.
  modport initiator (
    output valid,
    input  ready,
    output vc,
    output kind,
    output data
  );

  // receiver side of the link.
  modport target (
    input  valid,
    output ready,
    input  vc,
    input  kind,
    input  data
  );

endinterface

//--- hw/noc_flit_pkg.sv
package noc_flit_pkg;

  // position of a flit inside its packet.
  typedef enum logic [1:0] {
    HEAD   = 2'b00,  // opens a multi-flit packet.
    BODY   = 2'b01,
    TAIL   = 2'b10,  // closes a multi-flit packet.
    SINGLE = 2'b11   // whole packet in one flit.
  } noc_flit_kind_e;

  // output arbiter states.
  typedef enum logic {
    ARB_IDLE   = 1'b0,  // no packet in flight, free to pick a vc.
    ARB_LOCKED = 1'b1   // grant held until the tail goes out.
  } noc_arb_state_e;

  // true for flits that may start a packet.
  function automatic logic is_packet_start(noc_flit_kind_e kind);
    return (kind == HEAD) || (kind == SINGLE);
  endfunction

  // true for flits that end a packet.
  function automatic logic is_packet_end(noc_flit_kind_e kind);
    return (kind == TAIL) || (kind == SINGLE);
  endfunction

endpackage

//--- hw/noc_output_port.sv
`timescale 1ns/1ps

module noc_output_port
  import noc_config_pkg::*, noc_flit_pkg::*;
#(
  parameter int  CHANNELS   = NOC_CHANNELS,
  parameter int  DEPTH      = NOC_DEPTH,
  parameter int  DATA_WIDTH = NOC_DATA_WIDTH,
  localparam int VC_WIDTH   = noc_vc_width(CHANNELS)
)(
  input  logic                  i_clk,
  input  logic                  i_reset,
  // input link.
  input  logic                  i_in_valid,
  output logic                  o_in_ready,
  input  logic [VC_WIDTH-1:0]   i_in_vc,
  input  noc_flit_kind_e        i_in_kind,
  input  logic [DATA_WIDTH-1:0] i_in_data,
  // output link.
  output logic                  o_out_valid,
  input  logic                  i_out_ready,
  output logic [VC_WIDTH-1:0]   o_out_vc,
  output noc_flit_kind_e        o_out_kind,
  output logic [DATA_WIDTH-1:0] o_out_data
);

  noc_flit_if #(.CHANNELS(CHANNELS), .DATA_WIDTH(DATA_WIDTH)) wr_if[CHANNELS] ();
  noc_flit_if #(.CHANNELS(CHANNELS), .DATA_WIDTH(DATA_WIDTH)) rd_if[CHANNELS] ();
  noc_flit_if #(.CHANNELS(CHANNELS), .DATA_WIDTH(DATA_WIDTH)) out_if ();

  noc_vc_steer #(
    .CHANNELS   (CHANNELS   ),
    .DATA_WIDTH (DATA_WIDTH )
  ) u_steer (
    .i_in_valid (i_in_valid ),
    .o_in_ready (o_in_ready ),
    .i_in_vc    (i_in_vc    ),
    .i_in_kind  (i_in_kind  ),
    .i_in_data  (i_in_data  ),
    .vc_out_if  (wr_if      )
  );

  // one buffer per virtual channel.
  for (genvar i = 0; i < CHANNELS; i++) begin : g_vc_buffer
    noc_vc_buffer #(
      .CHANNELS   (CHANNELS   ),
      .DEPTH      (DEPTH      ),
      .DATA_WIDTH (DATA_WIDTH )
    ) u_buffer (
      .i_clk      (i_clk      ),
      .i_reset    (i_reset    ),
      .wr_if      (wr_if[i]   ),
      .rd_if      (rd_if[i]   )
    );
  end

  noc_vc_arbiter_mux #(
    .CHANNELS   (CHANNELS   ),
    .DATA_WIDTH (DATA_WIDTH )
  ) u_arbiter_mux (
    .i_clk      (i_clk      ),
    .i_reset    (i_reset    ),
    .vc_in_if   (rd_if      ),
    .out_if     (out_if     )
  );

  assign o_out_valid  = out_if.valid;
  assign out_if.ready = i_out_ready;
  assign o_out_vc     = out_if.vc;
  assign o_out_kind   = out_if.kind;
  assign o_out_data   = out_if.data;

endmodule

//--- hw/noc_vc_arbiter_mux.sv
`timescale 1ns/1ps

module noc_vc_arbiter_mux
  import noc_config_pkg::*, noc_flit_pkg::*;
#(
  parameter int CHANNELS   = NOC_CHANNELS,
  parameter int DATA_WIDTH = NOC_DATA_WIDTH
)(
  input logic           i_clk,
  input logic           i_reset,
  noc_flit_if.target    vc_in_if[CHANNELS],
  noc_flit_if.initiator out_if
);

  localparam int VC_WIDTH = noc_vc_width(CHANNELS);
  localparam logic [VC_WIDTH-1:0] LAST_VC = VC_WIDTH'(CHANNELS - 1);

  noc_arb_state_e        state;
  logic [CHANNELS-1:0]   grant_q;   // held grant while locked.
  logic [VC_WIDTH-1:0]   rr_ptr;    // first vc looked at in idle.

  logic [CHANNELS-1:0]   in_valid;
  logic [CHANNELS-1:0]   in_start;  // valid head or single flit.
  logic [VC_WIDTH-1:0]   in_vc[CHANNELS];
  noc_flit_kind_e        in_kind[CHANNELS];
  logic [DATA_WIDTH-1:0] in_data[CHANNELS];

  logic [CHANNELS-1:0]   idle_grant;
  logic [CHANNELS-1:0]   grant;
  logic [VC_WIDTH-1:0]   grant_vc;
  logic [VC_WIDTH-1:0]   next_ptr;
  logic                  transfer;
  logic                  packet_done;

  for (genvar i = 0; i < CHANNELS; i++) begin : g_vc_in
    assign in_valid[i] = vc_in_if[i].valid;
    assign in_start[i] = vc_in_if[i].valid && is_packet_start(vc_in_if[i].kind);
    assign in_vc[i]    = vc_in_if[i].vc;
    assign in_kind[i]  = vc_in_if[i].kind;
    assign in_data[i]  = vc_in_if[i].data;

    assign vc_in_if[i].ready = grant[i] && out_if.ready;  // ready demux.
  end

  // round-robin search from rr_ptr upward.
  // walking backwards lets the vc nearest to the pointer overwrite the rest.
  always_comb begin
    idle_grant = '0;
    for (int offset = CHANNELS - 1; offset >= 0; offset--) begin
      if (in_start[(int'(rr_ptr) + offset) % CHANNELS]) begin
        idle_grant = '0;
        idle_grant[(int'(rr_ptr) + offset) % CHANNELS] = 1'b1;
      end
    end
  end

  assign grant = (state == ARB_LOCKED) ? grant_q : idle_grant;

  // one-hot flit mux.
  always_comb begin
    out_if.vc   = '0;
    out_if.kind = HEAD;
    out_if.data = '0;
    grant_vc    = '0;
    for (int i = 0; i < CHANNELS; i++) begin
      if (grant[i]) begin
        out_if.vc   = in_vc[i];
        out_if.kind = in_kind[i];
        out_if.data = in_data[i];
        grant_vc    = VC_WIDTH'(i);
      end
    end
  end

  assign out_if.valid = |(grant & in_valid);
  assign transfer     = out_if.valid && out_if.ready;
  assign packet_done  = transfer && is_packet_end(out_if.kind);
  assign next_ptr     = (grant_vc == LAST_VC) ? '0 : grant_vc + 1'b1;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state   <= ARB_IDLE;
      grant_q <= '0;
      rr_ptr  <= '0;
    end else begin
      case (state)
        ARB_IDLE: begin
          if (packet_done) begin
            rr_ptr <= next_ptr;  // single flit went straight through.
          end else if (|idle_grant) begin
            state   <= ARB_LOCKED;
            grant_q <= idle_grant;
          end
        end
        ARB_LOCKED: begin
          if (packet_done) begin
            state   <= ARB_IDLE;
            grant_q <= '0;
            rr_ptr  <= next_ptr;
          end
        end
        default: state <= ARB_IDLE;
      endcase
    end
  end

  a_grant_onehot: assert property (
    @(posedge i_clk) disable iff (i_reset)
    $onehot0(grant)
  ) else $error("arbiter grant %b is not one-hot", grant);

  // packets must not interleave on the output link.
  a_grant_held: assert property (
    @(posedge i_clk) disable iff (i_reset)
    ((state == ARB_LOCKED) && !packet_done) |=> (grant == $past(grant))
  ) else $error("arbiter grant moved inside a packet");

endmodule

//--- hw/noc_vc_buffer.sv
`timescale 1ns/1ps

module noc_vc_buffer
  import noc_config_pkg::*, noc_flit_pkg::*;
#(
  parameter int CHANNELS   = NOC_CHANNELS,
  parameter int DEPTH      = NOC_DEPTH,
  parameter int DATA_WIDTH = NOC_DATA_WIDTH
)(
  input logic           i_clk,
  input logic           i_reset,
  noc_flit_if.target    wr_if,
  noc_flit_if.initiator rd_if
);

  localparam int VC_WIDTH  = noc_vc_width(CHANNELS);
  localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_WIDTH = $clog2(DEPTH + 1);

  localparam logic [PTR_WIDTH-1:0] LAST_PTR   = PTR_WIDTH'(DEPTH - 1);
  localparam logic [CNT_WIDTH-1:0] FULL_COUNT = CNT_WIDTH'(DEPTH);

  logic [VC_WIDTH-1:0]   vc_mem[DEPTH];
  noc_flit_kind_e        kind_mem[DEPTH];
  logic [DATA_WIDTH-1:0] data_mem[DEPTH];

  logic [PTR_WIDTH-1:0] wr_ptr;
  logic [PTR_WIDTH-1:0] rd_ptr;
  logic [CNT_WIDTH-1:0] count;   // flits held.
  logic                 full;
  logic                 empty;
  logic                 push;
  logic                 pop;

  assign full  = (count == FULL_COUNT);
  assign empty = (count == '0);
  assign push  = wr_if.valid && wr_if.ready;
  assign pop   = rd_if.valid && rd_if.ready;

  assign wr_if.ready = !full;
  assign rd_if.valid = !empty;  // registered, so a new flit shows one cycle later.
  assign rd_if.vc    = vc_mem[rd_ptr];
  assign rd_if.kind  = kind_mem[rd_ptr];
  assign rd_if.data  = data_mem[rd_ptr];

  always_ff @(posedge i_clk) begin
    if (push) begin
      vc_mem[wr_ptr]   <= wr_if.vc;
      kind_mem[wr_ptr] <= wr_if.kind;
      data_mem[wr_ptr] <= wr_if.data;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;  // wrap at depth.
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // idle, or a read and a write together.
      endcase
    end
  end

  // a full buffer that is not read must not take a flit in.
  a_no_write_when_full: assert property (
    @(posedge i_clk) disable iff (i_reset)
    (full && !pop) |=> (count == $past(count))
  ) else $error("vc buffer took a write while full");

  a_count_range: assert property (
    @(posedge i_clk) disable iff (i_reset)
    count <= FULL_COUNT
  ) else $error("vc buffer count %0d above depth %0d", count, DEPTH);

endmodule

//--- hw/noc_vc_steer.sv
`timescale 1ns/1ps

module noc_vc_steer
  import noc_config_pkg::*, noc_flit_pkg::*;
#(
  parameter int  CHANNELS   = NOC_CHANNELS,
  parameter int  DATA_WIDTH = NOC_DATA_WIDTH,
  localparam int VC_WIDTH   = noc_vc_width(CHANNELS)
)(
  input  logic                  i_in_valid,
  output logic                  o_in_ready,
  input  logic [VC_WIDTH-1:0]   i_in_vc,
  input  noc_flit_kind_e        i_in_kind,
  input  logic [DATA_WIDTH-1:0] i_in_data,
  noc_flit_if.initiator         vc_out_if[CHANNELS]
);

  logic [CHANNELS-1:0] vc_select;  // one-hot decode of i_in_vc.
  logic [CHANNELS-1:0] vc_ready;
  logic                vc_in_range;

  assign vc_in_range = (int'(i_in_vc) < CHANNELS);

  for (genvar i = 0; i < CHANNELS; i++) begin : g_vc_out
    assign vc_select[i] = (int'(i_in_vc) == i);

    // the flit fields fan out to every buffer, only valid is steered.
    assign vc_out_if[i].valid = i_in_valid && vc_select[i];
    assign vc_out_if[i].vc    = i_in_vc;
    assign vc_out_if[i].kind  = i_in_kind;
    assign vc_out_if[i].data  = i_in_data;

    assign vc_ready[i] = vc_out_if[i].ready;
  end

  // ready comes back from the addressed buffer only.
  always_comb begin
    o_in_ready = 1'b0;
    for (int i = 0; i < CHANNELS; i++) begin
      if (vc_select[i]) begin
        o_in_ready = vc_ready[i];
      end
    end
  end

  // an index past the last vc would drop the flit without a handshake.
  always_comb begin
    if (i_in_valid) begin
      a_vc_in_range: assert (vc_in_range)
        else $error("flit addressed vc %0d, port has %0d", i_in_vc, CHANNELS);
    end
  end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# compile the output port testbench with verilator, run it and check the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=sim_noc_output_port

rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module noc_output_port_tb -f build.f -o "$BIN" \
  && ./obj_dir/"$BIN" > "$LOG" 2>&1 \
  || echo "build or simulation did not complete" >> "$LOG"

cat "$LOG"

grep -qx "Testbench passed" "$LOG" \
  && echo "result: pass" \
  || { echo "result: fail"; exit 1; }

//--- tb/noc_output_port_tb.sv
`timescale 1ns/1ps

module noc_output_port_tb
  import noc_config_pkg::*, noc_flit_pkg::*;
();

  localparam int VC_W         = noc_vc_width(NOC_CHANNELS);
  localparam int ENTRY_W      = VC_W + 2 + NOC_DATA_WIDTH;  // {vc, kind, data}.
  localparam int DRIVE_DELAY  = 10;                         // ns after the rising edge.
  localparam int WAIT_LIMIT   = 200;                        // cycles per wait.
  localparam int RUN_LIMIT_NS = 2_000_000;

  logic                      clk;
  logic                      reset;
  logic                      i_in_valid;
  logic                      o_in_ready;
  logic [VC_W-1:0]           i_in_vc;
  noc_flit_kind_e            i_in_kind;
  logic [NOC_DATA_WIDTH-1:0] i_in_data;
  logic                      o_out_valid;
  logic                      i_out_ready;
  logic [VC_W-1:0]           o_out_vc;
  noc_flit_kind_e            o_out_kind;
  logic [NOC_DATA_WIDTH-1:0] o_out_data;

  logic [ENTRY_W-1:0] expected[$];   // accepted flits, in input order.
  int                 out_order[$];  // vc of every flit seen at the output.
  int                 open_vc;       // vc of the packet in flight at the output, or -1.
  int                 seed;
  int                 error_count;
  int                 check_count;
  int                 test_count;
  int                 test_errors;
  logic               random_ready;

  tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(4)) u_clock_gen (
    .o_clk   (clk  ),
    .o_reset (reset)
  );

  noc_output_port #(
    .CHANNELS   (NOC_CHANNELS  ),
    .DEPTH      (NOC_DEPTH     ),
    .DATA_WIDTH (NOC_DATA_WIDTH)
  ) i_noc_output_port (
    .i_clk       (clk        ),
    .i_reset     (reset      ),
    .i_in_valid  (i_in_valid ),
    .o_in_ready  (o_in_ready ),
    .i_in_vc     (i_in_vc    ),
    .i_in_kind   (i_in_kind  ),
    .i_in_data   (i_in_data  ),
    .o_out_valid (o_out_valid),
    .i_out_ready (i_out_ready),
    .o_out_vc    (o_out_vc   ),
    .o_out_kind  (o_out_kind ),
    .o_out_data  (o_out_data )
  );

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expect_value);
    check_count++;
    if (actual !== expect_value) begin
      $display("error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, actual,
               expect_value);
      error_count++;
    end
  endtask

  task automatic start_test();
    test_errors = error_count;
    out_order.delete();
  endtask

  task automatic end_test(input string name);
    test_count++;
    if (error_count == test_errors) $display("test %s: ok", name);
    else $display("test %s: %0d errors", name, error_count - test_errors);
  endtask

  task automatic wait_reset();
    int waited;
    waited = 0;
    @(posedge clk);
    while (reset && waited < WAIT_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (reset) begin
      $display("timeout: reset was never released");
      error_count++;
    end
    #DRIVE_DELAY;
  endtask

  task automatic start_flit(input int vc, input noc_flit_kind_e kind,
                            input logic [NOC_DATA_WIDTH-1:0] data);
    i_in_valid = 1'b1;
    i_in_vc    = VC_W'(vc);
    i_in_kind  = kind;
    i_in_data  = data;
  endtask

  // called at a falling edge, holds the flit until the input link takes it.
  task automatic finish_flit();
    int waited;
    waited = 0;
    while (!o_in_ready && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!o_in_ready) begin
      $display("timeout at %0t ns: input link never took the flit for vc %0d", $time, i_in_vc);
      error_count++;
    end else begin
      expected.push_back({i_in_vc, i_in_kind, i_in_data});
    end
    @(posedge clk);
    #DRIVE_DELAY;
    i_in_valid = 1'b0;
  endtask

  task automatic send_flit(input int vc, input noc_flit_kind_e kind);
    start_flit(vc, kind, NOC_DATA_WIDTH'($random(seed)));
    @(negedge clk);
    finish_flit();
  endtask

  task automatic send_packet(input int vc, input int len);
    noc_flit_kind_e kind;
    for (int k = 0; k < len; k++) begin
      if (len == 1) kind = SINGLE;
      else if (k == 0) kind = HEAD;
      else if (k == len - 1) kind = TAIL;
      else kind = BODY;
      send_flit(vc, kind);
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    @(negedge clk);
    while (expected.size() != 0 && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (expected.size() != 0) begin
      $display("timeout at %0t ns: %0d flits never left the output", $time, expected.size());
      error_count++;
      expected.delete();
    end
    if (open_vc >= 0) begin
      $display("packet on vc %0d never got its tail on the output", open_vc);
      error_count++;
      open_vc = -1;
    end
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  // matches an output flit against the oldest flit sent on the same vc.
  task automatic take_output();
    int                 idx;
    logic [ENTRY_W-1:0] entry;
    logic [VC_W-1:0]    entry_vc;
    idx = -1;
    for (int k = 0; k < expected.size(); k++) begin
      entry    = expected[k];
      entry_vc = entry[ENTRY_W-1 -: VC_W];
      if (idx < 0 && entry_vc == o_out_vc) idx = k;
    end
    out_order.push_back(int'(o_out_vc));
    if (idx < 0) begin
      $display("unexpected flit at %0t ns: vc %0d data 0x%0h was never sent", $time,
               o_out_vc, o_out_data);
      error_count++;
    end else begin
      entry = expected[idx];
      expected.delete(idx);
      check_value("o_out_kind", o_out_kind, entry[NOC_DATA_WIDTH +: 2]);
      check_value("o_out_data", o_out_data, entry[NOC_DATA_WIDTH-1:0]);
    end
    if (open_vc >= 0 && open_vc != int'(o_out_vc)) begin
      $display("interleave at %0t ns: vc %0d flit inside a packet of vc %0d", $time,
               o_out_vc, open_vc);
      error_count++;
    end
    if (o_out_kind == TAIL || o_out_kind == SINGLE) open_vc = -1;
    else open_vc = int'(o_out_vc);
  endtask

  // outputs are stable at the falling edge, a transfer follows at the next rising edge.
  always @(negedge clk) begin
    if (!reset && o_out_valid && i_out_ready) take_output();
  end

  always @(posedge clk) begin
    if (random_ready) begin
      #DRIVE_DELAY;
      i_out_ready = ($random(seed) % 3) != 0;  // ready about two cycles in three.
    end
  end

  task automatic test_reset_and_single();
    start_test();
    @(negedge clk);
    check_value("o_out_valid", o_out_valid, 1'b0);
    check_value("o_in_ready", o_in_ready, 1'b1);
    @(posedge clk);
    #DRIVE_DELAY;
    for (int vc = 0; vc < NOC_CHANNELS; vc++) send_flit(vc, SINGLE);
    wait_drain();
    check_value("output flit count", out_order.size(), NOC_CHANNELS);
    end_test("reset and single flits");
  endtask

  task automatic test_round_robin();
    start_test();
    for (int round = 0; round < 2; round++) begin
      out_order.delete();
      i_out_ready = 1'b0;
      for (int vc = 0; vc < NOC_CHANNELS; vc++) send_flit(vc, SINGLE);
      i_out_ready = 1'b1;
      wait_drain();
      check_value("output flit count", out_order.size(), NOC_CHANNELS);
      if (out_order.size() == NOC_CHANNELS) begin
        for (int k = 0; k < NOC_CHANNELS; k++) check_value("o_out_vc", out_order[k], k);
      end
    end
    end_test("round-robin order");
  endtask

  task automatic test_back_pressure();
    start_test();
    i_out_ready = 1'b0;
    for (int k = 0; k < NOC_DEPTH; k++) begin
      start_flit(2, SINGLE, NOC_DATA_WIDTH'($random(seed)));
      @(negedge clk);
      check_value("o_in_ready", o_in_ready, 1'b1);
      finish_flit();
    end
    start_flit(2, SINGLE, NOC_DATA_WIDTH'($random(seed)));
    @(negedge clk);
    check_value("o_in_ready", o_in_ready, 1'b0);  // buffer of vc 2 is full.
    @(posedge clk);
    #DRIVE_DELAY;
    i_out_ready = 1'b1;
    @(negedge clk);
    finish_flit();
    wait_drain();
    check_value("output flit count", out_order.size(), NOC_DEPTH + 1);
    end_test("back-pressure");
  endtask

  task automatic test_packet_lock();
    start_test();
    i_out_ready = 1'b0;
    // the two packets arrive interleaved at the input.
    send_flit(1, HEAD);
    send_flit(3, HEAD);
    send_flit(1, BODY);
    send_flit(3, BODY);
    send_flit(1, TAIL);
    send_flit(3, TAIL);
    i_out_ready = 1'b1;
    wait_drain();
    check_value("output flit count", out_order.size(), 6);
    if (out_order.size() == 6) begin
      for (int k = 1; k < 3; k++) check_value("o_out_vc", out_order[k], out_order[0]);
      for (int k = 4; k < 6; k++) check_value("o_out_vc", out_order[k], out_order[3]);
    end
    end_test("packet lock");
  endtask

  task automatic test_random_traffic();
    int vc;
    int len;
    start_test();
    random_ready = 1'b1;
    for (int p = 0; p < 16; p++) begin
      vc  = $unsigned($random(seed)) % NOC_CHANNELS;
      len = 1 + $unsigned($random(seed)) % 4;
      send_packet(vc, len);
    end
    random_ready = 1'b0;
    @(posedge clk);
    #DRIVE_DELAY;
    i_out_ready = 1'b1;
    wait_drain();
    end_test("random traffic");
  endtask

  initial begin
    seed         = 43318;
    error_count  = 0;
    check_count  = 0;
    test_count   = 0;
    test_errors  = 0;
    open_vc      = -1;
    random_ready = 1'b0;
    i_in_valid   = 1'b0;
    i_in_vc      = '0;
    i_in_kind    = HEAD;
    i_in_data    = '0;
    i_out_ready  = 1'b1;
    wait_reset();
    test_reset_and_single();
    test_round_robin();  // last single went out on the top vc, so the pointer is back on vc 0.
    test_back_pressure();
    test_packet_lock();
    test_random_traffic();
    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin
    #(RUN_LIMIT_NS);
    $display("simulation stopped: run time limit reached");
    $display("Testbench failed");
    $finish;
  end

endmodule

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 4
)(
  output logic o_clk,
  output logic o_reset
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

  // reset drops just after the last reset edge.
  initial begin
    o_reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge o_clk);
    #1 o_reset = 1'b0;
  end

endmodule
